// File: project.f
+incdir+include
src/padframe_pkg.sv
src/padcfg_decode.sv
src/padcfg_regfile.sv
src/padcfg_rsp.sv
src/pad_mux.sv
src/padframe_top.sv
verif/padframe_props.sv
verif/padframe_tb.sv

// File: Bender.yml
package:
  name: padframe

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/padframe_pkg.sv
      - src/padcfg_decode.sv
      - src/padcfg_regfile.sv
      - src/padcfg_rsp.sv
      - src/pad_mux.sv
      - src/padframe_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/padframe_props.sv
      - verif/padframe_tb.sv

// File: verif/padframe_tb.sv
////////////////////////////////////////
// Directed testbench for the pad frame top level
// Programs selects over the register bus, checks routing
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "padframe_settings.svh"

module padframe_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 5;
  localparam int RESET_CYCLES = 10;
  // Register requests plus routing cycles over all tests
  localparam int NUM_OPS      = 75;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 4 + RESET_CYCLES;

  logic                                                clk;
  logic                                                rst_n;
  padframe_pkg::reg_req_t                              req;
  padframe_pkg::reg_rsp_t                              rsp;
  padframe_pkg::func_to_pad_t [`PADFRAME_N_FUNCS-1:0] func_to_pad;
  padframe_pkg::pad_to_func_t [`PADFRAME_N_FUNCS-1:0] pad_to_func;
  logic [`PADFRAME_N_PADS-1:0]                         pad_in;
  logic [`PADFRAME_N_PADS-1:0]                         pad_out;
  logic [`PADFRAME_N_PADS-1:0]                         pad_oe;

  logic [31:0] lfsr_state;
  logic [1:0]  model_sel [`PADFRAME_N_PADS];
  int          value_errors;
  int          protocol_errors;

  padframe_top dut_i (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .req_i         ( req         ),
    .rsp_o         ( rsp         ),
    .func_to_pad_i ( func_to_pad ),
    .pad_to_func_o ( pad_to_func ),
    .pad_in_i      ( pad_in      ),
    .pad_out_o     ( pad_out     ),
    .pad_oe_o      ( pad_oe      )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
    value_errors++;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic drive_req(input logic write, input logic [7:0] addr,
                           input logic [31:0] wdata);
    req.valid = 1'b1;
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
  endtask

  task automatic clear_req();
    req = '0;
  endtask

  // Response of the request accepted at the last edge
  task automatic take_rsp(input logic [7:0] addr, output logic err,
                          output logic [31:0] rdata);
    if (!rsp.valid) begin
      $display("No response one cycle after the request to address 0x%h", addr);
      protocol_errors++;
    end
    err   = rsp.error;
    rdata = rsp.rdata;
  endtask

  task automatic reg_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic err,
                            output logic [31:0] rdata);
    drive_req(write, addr, wdata);
    next_cycle();
    clear_req();
    take_rsp(addr, err, rdata);
  endtask

  task automatic read_all_pads();
    logic        err;
    logic [31:0] rdata;
    for (int p = 0; p < `PADFRAME_N_PADS; p++) begin
      reg_access(1'b0, 8'(p * 4), '0, err, rdata);
      if (err !== 1'b0) report_mismatch("rsp_o.error", 32'h0, {31'b0, err});
      if (rdata !== {30'b0, model_sel[p]}) begin
        report_mismatch($sformatf("rsp_o.rdata pad %0d", p), {30'b0, model_sel[p]}, rdata);
      end
    end
  endtask

  task automatic check_out_routing();
    logic [`PADFRAME_N_PADS-1:0] exp_out;
    logic [`PADFRAME_N_PADS-1:0] exp_oe;
    for (int p = 0; p < `PADFRAME_N_PADS; p++) begin
      exp_out[p] = func_to_pad[model_sel[p]].out[p];
      exp_oe[p]  = func_to_pad[model_sel[p]].oe[p];
    end
    if (pad_out !== exp_out) report_mismatch("pad_out_o", 32'(exp_out), 32'(pad_out));
    if (pad_oe !== exp_oe) report_mismatch("pad_oe_o", 32'(exp_oe), 32'(pad_oe));
  endtask

  task automatic test_reset_state();
    read_all_pads();
    for (int i = 0; i < 2; i++) begin
      func_to_pad = {random_bits(32), random_bits(32)};
      @(negedge clk);
      if (pad_out !== func_to_pad[padframe_pkg::FUNC_GPIO].out) begin
        report_mismatch("pad_out_o", 32'(func_to_pad[padframe_pkg::FUNC_GPIO].out),
                        32'(pad_out));
      end
      if (pad_oe !== func_to_pad[padframe_pkg::FUNC_GPIO].oe) begin
        report_mismatch("pad_oe_o", 32'(func_to_pad[padframe_pkg::FUNC_GPIO].oe),
                        32'(pad_oe));
      end
      next_cycle();
    end
  endtask

  task automatic test_write_read();
    logic [1:0]  sel;
    logic        err;
    logic [31:0] rdata;
    for (int p = 0; p < `PADFRAME_N_PADS; p++) begin
      sel = 2'(random_bits(2));
      reg_access(1'b1, 8'(p * 4), {30'(random_bits(30)), sel}, err, rdata);
      model_sel[p] = sel;
      if (err !== 1'b0) report_mismatch("rsp_o.error", 32'h0, {31'b0, err});
      if (rdata !== 32'h0) report_mismatch("rsp_o.rdata", 32'h0, rdata);
    end
    read_all_pads();
  endtask

  task automatic test_invalid_addr();
    logic [7:0]  bad_addrs [8];
    logic        err;
    logic [31:0] rdata;
    // Misaligned first, then word indexes past the last pad
    bad_addrs = '{8'h01, 8'h06, 8'h0B, 8'h1F, 8'h20, 8'h3C, 8'h80, 8'hFC};
    for (int i = 0; i < 8; i++) begin
      reg_access(i[0] == 1'b0, bad_addrs[i], random_bits(32), err, rdata);
      if (err !== 1'b1) report_mismatch("rsp_o.error", 32'h1, {31'b0, err});
      if (rdata !== 32'h0) report_mismatch("rsp_o.rdata", 32'h0, rdata);
    end
    read_all_pads();
  endtask

  task automatic test_output_routing();
    logic [1:0]  sel;
    logic        err;
    logic [31:0] rdata;
    sel = 2'(random_bits(2));
    // Pads 0 to 3 cover all four functions
    for (int p = 0; p < `PADFRAME_N_PADS; p++) begin
      model_sel[p] = 2'(p) ^ sel;
      reg_access(1'b1, 8'(p * 4), {30'b0, model_sel[p]}, err, rdata);
      if (err !== 1'b0) report_mismatch("rsp_o.error", 32'h0, {31'b0, err});
    end
    for (int i = 0; i < 4; i++) begin
      func_to_pad = {random_bits(32), random_bits(32)};
      @(negedge clk);
      check_out_routing();
      next_cycle();
    end
  endtask

  task automatic test_input_routing();
    logic [`PADFRAME_N_PADS-1:0] exp_in;
    for (int i = 0; i < 4; i++) begin
      pad_in = random_bits(`PADFRAME_N_PADS);
      @(negedge clk);
      for (int f = 0; f < `PADFRAME_N_FUNCS; f++) begin
        for (int p = 0; p < `PADFRAME_N_PADS; p++) begin
          exp_in[p] = (model_sel[p] == 2'(f)) ? pad_in[p] : 1'b0;
        end
        if (pad_to_func[f].in !== exp_in) begin
          report_mismatch($sformatf("pad_to_func_o[%0d].in", f), 32'(exp_in),
                          32'(pad_to_func[f].in));
        end
      end
      next_cycle();
    end
  endtask

  task automatic test_back_to_back();
    logic [1:0]  new_sel;
    logic [7:0]  addr;
    logic        err;
    logic [31:0] rdata;
    func_to_pad = {random_bits(32), random_bits(32)};
    for (int p = 0; p < `PADFRAME_N_PADS; p++) begin
      new_sel = model_sel[p] + 2'd1;
      addr    = 8'(p * 4);
      drive_req(1'b1, addr, {30'(random_bits(30)), new_sel});
      next_cycle();
      // Read of the same pad right behind the write
      drive_req(1'b0, addr, '0);
      take_rsp(addr, err, rdata);
      model_sel[p] = new_sel;
      if (err !== 1'b0) report_mismatch("rsp_o.error", 32'h0, {31'b0, err});
      if (rdata !== 32'h0) report_mismatch("rsp_o.rdata", 32'h0, rdata);
      if (pad_out[p] !== func_to_pad[new_sel].out[p]) begin
        report_mismatch($sformatf("pad_out_o[%0d]", p), {31'b0, func_to_pad[new_sel].out[p]},
                        {31'b0, pad_out[p]});
      end
      next_cycle();
      clear_req();
      take_rsp(addr, err, rdata);
      if (err !== 1'b0) report_mismatch("rsp_o.error", 32'h0, {31'b0, err});
      if (rdata !== {30'b0, new_sel}) report_mismatch("rsp_o.rdata", {30'b0, new_sel}, rdata);
    end
    next_cycle();
    if (rsp.valid) begin
      $display("Response seen in a cycle that followed no request");
      protocol_errors++;
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    req             = '0;
    func_to_pad     = '0;
    pad_in          = '0;
    lfsr_state      = 32'h7c49;
    value_errors    = 0;
    protocol_errors = 0;
    for (int p = 0; p < `PADFRAME_N_PADS; p++) begin
      model_sel[p] = 2'd0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;

    test_reset_state();
    test_write_read();
    test_invalid_addr();
    test_output_routing();
    test_input_routing();
    test_back_to_back();

    $display("Done with %0d value errors, %0d protocol errors and %0d assertion failures",
             value_errors, protocol_errors, dut_i.i_props.fail_count);
    if (value_errors == 0 && protocol_errors == 0 && dut_i.i_props.fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/padframe_props.sv
////////////////////////////////////////
// Concurrent assertions on the pad frame top level
// Bound into every padframe_top instance
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module padframe_props (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input padframe_pkg::reg_req_t req_i,
  input padframe_pkg::reg_rsp_t rsp_o,
  input padframe_pkg::pad_sel_t sel_i
);

  int fail_count;

  // One response per request, one cycle later
  rsp_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.valid |=> rsp_o.valid)
    else begin
      $error("response valid missing one cycle after a request");
      fail_count++;
    end

  no_rsp_without_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !req_i.valid |=> !rsp_o.valid)
    else begin
      $error("response valid without a request in the previous cycle");
      fail_count++;
    end

  error_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.error |-> rsp_o.valid)
    else begin
      $error("response error high while response valid is low");
      fail_count++;
    end

  // All zero means every pad on GPIO
  gpio_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (sel_i == '0))
    else begin
      $error("pad selects not GPIO after reset release");
      fail_count++;
    end

endmodule

bind padframe_top padframe_props i_props (
  .clk_i   ( clk_i   ),
  .rst_n_i ( rst_n_i ),
  .req_i   ( req_i   ),
  .rsp_o   ( rsp_o   ),
  .sel_i   ( sel     )
);

`default_nettype wire

// File: src/padframe_top.sv
////////////////////////////////////////
// Pad frame top level
// Register-programmed routing of eight pads to four functions
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "padframe_settings.svh"

module padframe_top (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  // Configuration bus
  input  padframe_pkg::reg_req_t                              req_i,
  output padframe_pkg::reg_rsp_t                              rsp_o,
  // Function side
  input  padframe_pkg::func_to_pad_t [`PADFRAME_N_FUNCS-1:0] func_to_pad_i,
  output padframe_pkg::pad_to_func_t [`PADFRAME_N_FUNCS-1:0] pad_to_func_o,
  // Pad side
  input  logic [`PADFRAME_N_PADS-1:0]                         pad_in_i,
  output logic [`PADFRAME_N_PADS-1:0]                         pad_out_o,
  output logic [`PADFRAME_N_PADS-1:0]                         pad_oe_o
);

  padframe_pkg::reg_cmd_t  cmd;
  padframe_pkg::pad_sel_t  sel;
  padframe_pkg::pad_func_e rd_sel;

  padcfg_decode i_decode (
    .req_i ( req_i ),
    .cmd_o ( cmd   )
  );

  padcfg_regfile i_regfile (
    .clk_i    ( clk_i   ),
    .rst_n_i  ( rst_n_i ),
    .cmd_i    ( cmd     ),
    .sel_o    ( sel     ),
    .rd_sel_o ( rd_sel  )
  );

  padcfg_rsp i_rsp (
    .clk_i    ( clk_i   ),
    .rst_n_i  ( rst_n_i ),
    .cmd_i    ( cmd     ),
    .rd_sel_i ( rd_sel  ),
    .rsp_o    ( rsp_o   )
  );

  // Routing follows the registered selects
  pad_mux i_pad_mux (
    .sel_i         ( sel           ),
    .func_to_pad_i ( func_to_pad_i ),
    .pad_in_i      ( pad_in_i      ),
    .pad_to_func_o ( pad_to_func_o ),
    .pad_out_o     ( pad_out_o     ),
    .pad_oe_o      ( pad_oe_o      )
  );

endmodule

`default_nettype wire

// File: src/pad_mux.sv
////////////////////////////////////////
// Pad multiplexer
// Drives each pad from the function its select names and
// returns pad inputs only to the owning function
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "padframe_settings.svh"

module pad_mux (
  input  padframe_pkg::pad_sel_t                              sel_i,
  input  padframe_pkg::func_to_pad_t [`PADFRAME_N_FUNCS-1:0] func_to_pad_i,
  input  logic [`PADFRAME_N_PADS-1:0]                         pad_in_i,
  output padframe_pkg::pad_to_func_t [`PADFRAME_N_FUNCS-1:0] pad_to_func_o,
  output logic [`PADFRAME_N_PADS-1:0]                         pad_out_o,
  output logic [`PADFRAME_N_PADS-1:0]                         pad_oe_o
);

  // Outbound path
  always_comb begin
    for (int p = 0; p < `PADFRAME_N_PADS; p++) begin
      pad_out_o[p] = func_to_pad_i[sel_i[p]].out[p];
      pad_oe_o[p]  = func_to_pad_i[sel_i[p]].oe[p];
    end
  end

  // Inbound path, non-owners see zero
  always_comb begin
    for (int f = 0; f < `PADFRAME_N_FUNCS; f++) begin
      for (int p = 0; p < `PADFRAME_N_PADS; p++) begin
        if (sel_i[p] == padframe_pkg::pad_func_e'(f)) begin
          pad_to_func_o[f].in[p] = pad_in_i[p];
        end else begin
          pad_to_func_o[f].in[p] = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/padcfg_rsp.sv
////////////////////////////////////////
// Response stage of the configuration bus
// Returns valid, error and read data one cycle after a request
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "padframe_settings.svh"

module padcfg_rsp (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  padframe_pkg::reg_cmd_t  cmd_i,
  input  padframe_pkg::pad_func_e rd_sel_i,
  output padframe_pkg::reg_rsp_t  rsp_o
);

  localparam int unsigned SelW = $bits(padframe_pkg::pad_func_e);

  logic                        valid_q;
  logic                        error_q;
  logic [`PADFRAME_DATA_W-1:0] rdata_d;
  logic [`PADFRAME_DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      valid_q <= (cmd_i.op != padframe_pkg::OP_NONE);
      error_q <= (cmd_i.op == padframe_pkg::OP_INVALID);
    end
  end

  // Only reads carry data, zero extended
  assign rdata_d = (cmd_i.op == padframe_pkg::OP_READ) ?
                   {{(`PADFRAME_DATA_W-SelW){1'b0}}, rd_sel_i} : '0;

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign rsp_o.valid = valid_q;
  assign rsp_o.error = error_q;
  assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: src/padcfg_regfile.sv
////////////////////////////////////////
// Per-pad function select registers
// Written by decoded commands, read back for responses
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "padframe_settings.svh"

module padcfg_regfile (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  padframe_pkg::reg_cmd_t cmd_i,
  output padframe_pkg::pad_sel_t sel_o,
  output padframe_pkg::pad_func_e rd_sel_o
);

  padframe_pkg::pad_sel_t       sel_q;
  logic [`PADFRAME_N_PADS-1:0]  wr_en;

  // One-hot write enable for the addressed pad
  always_comb begin
    wr_en = '0;
    if (cmd_i.op == padframe_pkg::OP_WRITE) begin
      wr_en[cmd_i.idx] = 1'b1;
    end
  end

  for (genvar p = 0; p < `PADFRAME_N_PADS; p++) begin : g_sel_reg
    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        sel_q[p] <= padframe_pkg::FUNC_GPIO;
      end else if (wr_en[p]) begin
        sel_q[p] <= cmd_i.sel;
      end
    end
  end

  assign sel_o = sel_q;

  // Old contents, a write lands only at the clock edge
  assign rd_sel_o = sel_q[cmd_i.idx];

endmodule

`default_nettype wire

// File: src/padcfg_decode.sv
////////////////////////////////////////
// Register request decoder of the pad frame
// Classifies each request and splits out pad index and select
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "padframe_settings.svh"

module padcfg_decode (
  input  padframe_pkg::reg_req_t req_i,
  output padframe_pkg::reg_cmd_t cmd_o
);

  logic                          addr_aligned;
  logic [`PADFRAME_ADDR_W-3:0]   word_idx;
  logic                          in_range;
  padframe_pkg::reg_op_e         op;

  // One select register per 32-bit word
  assign word_idx     = req_i.addr[`PADFRAME_ADDR_W-1:2];
  assign addr_aligned = (req_i.addr[1:0] == 2'b00);
  assign in_range     = (word_idx < `PADFRAME_N_PADS);

  always_comb begin
    if (!req_i.valid) begin
      op = padframe_pkg::OP_NONE;
    end else if (!addr_aligned || !in_range) begin
      op = padframe_pkg::OP_INVALID;
    end else if (req_i.write) begin
      op = padframe_pkg::OP_WRITE;
    end else begin
      op = padframe_pkg::OP_READ;
    end
  end

  assign cmd_o.op  = op;
  assign cmd_o.idx = req_i.addr[`PADFRAME_IDX_W+1:2];
  // Upper write data bits carry no meaning
  assign cmd_o.sel = padframe_pkg::pad_func_e'(req_i.wdata[1:0]);

endmodule

`default_nettype wire

// File: src/padframe_pkg.sv
////////////////////////////////////////
// Types shared by the pad frame RTL and testbench
// Refer to them as padframe_pkg::name
////////////////////////////////////////

`default_nettype none

`include "padframe_settings.svh"

package padframe_pkg;

  // Function that owns a pad, also the select register value
  typedef enum logic [$clog2(`PADFRAME_N_FUNCS)-1:0] {
    FUNC_GPIO = 0,
    FUNC_UART = 1,
    FUNC_SPI  = 2,
    FUNC_I2C  = 3
  } pad_func_e;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_READ,
    OP_WRITE,
    OP_INVALID
  } reg_op_e;

  typedef struct packed {
    logic                        valid;
    logic                        write;
    logic [`PADFRAME_ADDR_W-1:0] addr;
    logic [`PADFRAME_DATA_W-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic                        valid;
    logic                        error;
    logic [`PADFRAME_DATA_W-1:0] rdata;
  } reg_rsp_t;

  // Decoded request
  typedef struct packed {
    reg_op_e                    op;
    logic [`PADFRAME_IDX_W-1:0] idx;
    pad_func_e                  sel;
  } reg_cmd_t;

  typedef pad_func_e [`PADFRAME_N_PADS-1:0] pad_sel_t;

  typedef struct packed {
    logic [`PADFRAME_N_PADS-1:0] out;
    logic [`PADFRAME_N_PADS-1:0] oe;
  } func_to_pad_t;

  typedef struct packed {
    logic [`PADFRAME_N_PADS-1:0] in;
  } pad_to_func_t;

endpackage

`default_nettype wire

// File: include/padframe_settings.svh
////////////////////////////////////////
// Sizes of the pad frame and its register bus
// Include wherever pad or bus widths are needed
////////////////////////////////////////

`ifndef PADFRAME_SETTINGS_SVH
`define PADFRAME_SETTINGS_SVH

// Pads and selectable functions
`define PADFRAME_N_PADS  8
`define PADFRAME_N_FUNCS 4

// Register bus widths
`define PADFRAME_ADDR_W 8
`define PADFRAME_DATA_W 32

// Bits needed to index a pad
`define PADFRAME_IDX_W 3

`endif
